// ==== rtl/stream_buffer_pkg.sv ====
package stream_buffer_pkg;

	//////////////////////////////////////////////////////////////////////
	// Data types
	//////////////////////////////////////////////////////////////////////

	// One producer sample
	typedef logic [15:0] sample_t;

	// Two samples packed for the bulk memory and the host
	typedef logic [31:0] word_t;

	// Fill level counted in 16-bit samples
	typedef logic [31:0] count_t;

	// Burst engine states
	typedef enum logic [1:0] {
		idle        = 2'd0,
		fill_burst  = 2'd1,
		drain_burst = 2'd2
	} engine_state_e;

	//////////////////////////////////////////////////////////////////////
	// Default sizes
	//////////////////////////////////////////////////////////////////////

	// Mini-FIFO depth is 64 words
	localparam int DEF_FIFO_ADDR_W = 6;

	// Bulk memory depth is 1024 words
	localparam int DEF_RAM_ADDR_W = 10;

	// Words moved per burst
	localparam int DEF_BURST_LEN = 16;

endpackage

// ==== rtl/sample_packer.sv ====
module sample_packer import stream_buffer_pkg::*; (
	input  logic    ti_clk,
	input  logic    reset,
	input  logic    write_to,
	input  sample_t data_in,
	output logic    pack_valid,
	output word_t   pack_word,
	output logic    half_held
);

	// First sample of the current pair
	sample_t low_sample;

	// Pair tracking and the push strobe
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			half_held  <= 1'b0;
			pack_valid <= 1'b0;
		end else begin
			pack_valid <= 1'b0;
			if (write_to) begin
				half_held  <= ~half_held;
				pack_valid <= half_held;
			end
		end
	end

	// Low sample goes to bits 15:0, high sample to bits 31:16
	always_ff @(posedge ti_clk) begin
		if (write_to) begin
			if (!half_held) begin
				low_sample <= data_in;
			end else begin
				pack_word <= {data_in, low_sample};
			end
		end
	end

endmodule

// ==== rtl/stage_fifo.sv ====
module stage_fifo import stream_buffer_pkg::*; #(
	parameter int addr_w = DEF_FIFO_ADDR_W
) (
	input  logic            ti_clk,
	input  logic            reset,
	input  logic            push,
	input  word_t           push_data,
	input  logic            pop,
	output word_t           pop_data,
	output logic [addr_w:0] count
);

	localparam int depth = 2 ** addr_w;

	word_t             mem [depth];
	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic              do_push;
	logic              do_pop;

	// A push into a full FIFO and a pop from an empty one are dropped
	assign do_push = push && (count != (addr_w + 1)'(depth));
	assign do_pop  = pop && (count != '0);

	//////////////////////////////////////////////////////////////////////
	// Pointers and entry count
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage array
	always_ff @(posedge ti_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Output register holds the last popped word when the FIFO runs dry
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			pop_data <= '0;
		end else if (do_pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

endmodule

// ==== rtl/bulk_ram.sv ====
module bulk_ram import stream_buffer_pkg::*; #(
	parameter int addr_w = DEF_RAM_ADDR_W
) (
	input  logic              ti_clk,
	input  logic              wr_en,
	input  logic [addr_w-1:0] wr_addr,
	input  word_t             wr_data,
	input  logic              rd_en,
	input  logic [addr_w-1:0] rd_addr,
	output word_t             rd_data
);

	// Stands in for the external SDRAM; addresses wrap around
	word_t mem [2 ** addr_w];

	always_ff @(posedge ti_clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Read data is valid the cycle after rd_en
	always_ff @(posedge ti_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// ==== rtl/burst_engine.sv ====
module burst_engine import stream_buffer_pkg::*; #(
	parameter int fifo_addr_w = DEF_FIFO_ADDR_W,
	parameter int ram_addr_w  = DEF_RAM_ADDR_W,
	parameter int burst_len   = DEF_BURST_LEN
) (
	input  logic                  ti_clk,
	input  logic                  reset,

	input  logic [fifo_addr_w:0]  in_count,
	output logic                  in_pop,
	input  word_t                 in_data,

	input  logic [fifo_addr_w:0]  out_count,
	output logic                  out_push,
	output word_t                 out_data,

	output logic                  ram_wr_en,
	output logic [ram_addr_w-1:0] ram_wr_addr,
	output word_t                 ram_wr_data,

	output logic                  ram_rd_en,
	output logic [ram_addr_w-1:0] ram_rd_addr,
	input  word_t                 ram_rd_data,

	output logic [ram_addr_w-1:0] ram_level
);

	localparam int fifo_depth = 2 ** fifo_addr_w;
	localparam int beat_w     = $clog2(burst_len + 1);

	engine_state_e         state;
	logic [beat_w-1:0]     beat;
	logic                  last_beat;
	logic                  fill_ok;
	logic                  drain_ok;
	logic                  wr_pending;
	logic                  rd_pending;
	logic [ram_addr_w-1:0] wr_addr;
	logic [ram_addr_w-1:0] rd_addr;

	// Words in the bulk memory; a lap wraps this back toward zero
	assign ram_level = wr_addr - rd_addr;

	//////////////////////////////////////////////////////////////////////
	// Start conditions
	//////////////////////////////////////////////////////////////////////

	assign fill_ok = in_count >= burst_len;

	// The last word of a previous drain may still be on its way to the output FIFO
	assign drain_ok = (ram_level >= burst_len)
		&& (int'(out_count) + int'(rd_pending) + burst_len <= fifo_depth);

	assign last_beat = beat == beat_w'(burst_len - 1);

	//////////////////////////////////////////////////////////////////////
	// Burst FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			state <= idle;
			beat  <= '0;
		end else begin
			case (state)
				idle: begin
					beat <= '0;
					// Fill has priority so the small input FIFO never backs up
					if (fill_ok) begin
						state <= fill_burst;
					end else if (drain_ok) begin
						state <= drain_burst;
					end
				end
				fill_burst, drain_burst: begin
					if (last_beat) begin
						state <= idle;
						beat  <= '0;
					end else begin
						beat <= beat + 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// One request per cycle while a burst runs
	assign in_pop    = state == fill_burst;
	assign ram_rd_en = state == drain_burst;

	//////////////////////////////////////////////////////////////////////
	// Data stage and addresses
	//////////////////////////////////////////////////////////////////////

	// Each request returns its word one cycle later
	always_ff @(posedge ti_clk) begin
		if (reset) begin
			wr_pending <= 1'b0;
			rd_pending <= 1'b0;
			wr_addr    <= '0;
			rd_addr    <= '0;
		end else begin
			wr_pending <= in_pop;
			rd_pending <= ram_rd_en;
			if (wr_pending) begin
				wr_addr <= wr_addr + 1'b1;
			end
			if (ram_rd_en) begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	// Input FIFO word goes into the bulk memory
	assign ram_wr_en   = wr_pending;
	assign ram_wr_addr = wr_addr;
	assign ram_wr_data = in_data;

	// Bulk memory word goes into the output FIFO
	assign ram_rd_addr = rd_addr;
	assign out_push    = rd_pending;
	assign out_data    = ram_rd_data;

endmodule

// ==== rtl/fill_monitor.sv ====
module fill_monitor import stream_buffer_pkg::*; #(
	parameter int fifo_addr_w = DEF_FIFO_ADDR_W,
	parameter int ram_addr_w  = DEF_RAM_ADDR_W
) (
	input  logic                  ti_clk,
	input  logic                  reset,
	input  logic [fifo_addr_w:0]  in_count,
	input  logic                  half_held,
	input  logic [fifo_addr_w:0]  out_count,
	input  logic [ram_addr_w-1:0] ram_level,
	input  logic [15:0]           usb_blocksize,
	output count_t                num_words_in_fifo,
	output count_t                in_fifo_numwords,
	output count_t                out_fifo_numwords,
	output count_t                ddr_numwords,
	output logic                  out_rdy
);

	count_t in_samples;
	count_t out_samples;
	count_t ram_samples;

	// Word counts to sample counts
	assign in_samples  = (count_t'(in_count) << 1) + count_t'(half_held);
	assign out_samples = count_t'(out_count) << 1;
	assign ram_samples = count_t'(ram_level) << 1;

	//////////////////////////////////////////////////////////////////////
	// Registered status
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge ti_clk) begin
		if (reset) begin
			in_fifo_numwords  <= '0;
			out_fifo_numwords <= '0;
			ddr_numwords      <= '0;
			num_words_in_fifo <= '0;
			out_rdy           <= 1'b0;
		end else begin
			in_fifo_numwords  <= in_samples;
			out_fifo_numwords <= out_samples;
			ddr_numwords      <= ram_samples;
			num_words_in_fifo <= in_samples + out_samples + ram_samples;
			// Host may read once a whole block sits in the output FIFO
			out_rdy <= count_t'(out_count) >= count_t'(usb_blocksize);
		end
	end

endmodule

// ==== rtl/stream_buffer_top.sv ====
module stream_buffer_top import stream_buffer_pkg::*; #(
	parameter int fifo_addr_w = DEF_FIFO_ADDR_W,
	parameter int ram_addr_w  = DEF_RAM_ADDR_W,
	parameter int burst_len   = DEF_BURST_LEN
) (
	input  logic        ti_clk,
	input  logic        reset,
	input  logic        write_to,
	input  sample_t     data_in,
	input  logic        read_from,
	input  logic [15:0] usb_blocksize,
	output word_t       data_out,
	output logic        out_rdy,
	output count_t      num_words_in_fifo,
	output count_t      in_fifo_numwords,
	output count_t      out_fifo_numwords,
	output count_t      ddr_numwords
);

	// Packer to input FIFO
	logic                  pack_valid;
	word_t                 pack_word;
	logic                  half_held;

	// Input FIFO to engine
	logic                  in_pop;
	word_t                 in_data;
	logic [fifo_addr_w:0]  in_count;

	// Engine to output FIFO
	logic                  out_push;
	word_t                 out_data;
	logic [fifo_addr_w:0]  out_count;

	// Bulk memory ports
	logic                  ram_wr_en;
	logic [ram_addr_w-1:0] ram_wr_addr;
	word_t                 ram_wr_data;
	logic                  ram_rd_en;
	logic [ram_addr_w-1:0] ram_rd_addr;
	word_t                 ram_rd_data;
	logic [ram_addr_w-1:0] ram_level;

	//////////////////////////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////////////////////////

	sample_packer packer (
		.ti_clk     (ti_clk),
		.reset      (reset),
		.write_to   (write_to),
		.data_in    (data_in),
		.pack_valid (pack_valid),
		.pack_word  (pack_word),
		.half_held  (half_held)
	);

	stage_fifo #(.addr_w(fifo_addr_w)) in_fifo (
		.ti_clk    (ti_clk),
		.reset     (reset),
		.push      (pack_valid),
		.push_data (pack_word),
		.pop       (in_pop),
		.pop_data  (in_data),
		.count     (in_count)
	);

	burst_engine #(
		.fifo_addr_w (fifo_addr_w),
		.ram_addr_w  (ram_addr_w),
		.burst_len   (burst_len)
	) engine (
		.ti_clk      (ti_clk),
		.reset       (reset),
		.in_count    (in_count),
		.in_pop      (in_pop),
		.in_data     (in_data),
		.out_count   (out_count),
		.out_push    (out_push),
		.out_data    (out_data),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.ram_rd_en   (ram_rd_en),
		.ram_rd_addr (ram_rd_addr),
		.ram_rd_data (ram_rd_data),
		.ram_level   (ram_level)
	);

	bulk_ram #(.addr_w(ram_addr_w)) ram (
		.ti_clk  (ti_clk),
		.wr_en   (ram_wr_en),
		.wr_addr (ram_wr_addr),
		.wr_data (ram_wr_data),
		.rd_en   (ram_rd_en),
		.rd_addr (ram_rd_addr),
		.rd_data (ram_rd_data)
	);

	// Host reads straight from here
	stage_fifo #(.addr_w(fifo_addr_w)) out_fifo (
		.ti_clk    (ti_clk),
		.reset     (reset),
		.push      (out_push),
		.push_data (out_data),
		.pop       (read_from),
		.pop_data  (data_out),
		.count     (out_count)
	);

	//////////////////////////////////////////////////////////////////////
	// Status
	//////////////////////////////////////////////////////////////////////

	fill_monitor #(
		.fifo_addr_w (fifo_addr_w),
		.ram_addr_w  (ram_addr_w)
	) monitor (
		.ti_clk            (ti_clk),
		.reset             (reset),
		.in_count          (in_count),
		.half_held         (half_held),
		.out_count         (out_count),
		.ram_level         (ram_level),
		.usb_blocksize     (usb_blocksize),
		.num_words_in_fifo (num_words_in_fifo),
		.in_fifo_numwords  (in_fifo_numwords),
		.out_fifo_numwords (out_fifo_numwords),
		.ddr_numwords      (ddr_numwords),
		.out_rdy           (out_rdy)
	);

endmodule

// ==== test/stream_buffer_checks.svh ====
`ifndef STREAM_BUFFER_CHECKS_SVH
`define STREAM_BUFFER_CHECKS_SVH

//////////////////////////////////////////////////////////////////////
// Compare tasks for each kind of DUT result
//////////////////////////////////////////////////////////////////////

// Host data word
task automatic check_word(input string name, input word_t got, input word_t exp);
	if (got !== exp) begin
		fail_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
	end
endtask

// Fill level in samples
task automatic check_count(input string name, input count_t got, input count_t exp);
	if (got !== exp) begin
		fail_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
	end
endtask

// Single status bit
task automatic check_flag(input string name, input bit got, input bit exp);
	if (got !== exp) begin
		fail_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	end
endtask

`endif

// ==== test/stream_buffer_tb.sv ====
module stream_buffer_tb import stream_buffer_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_rows      = 6;
	localparam int settle_cycles = 300;
	localparam int fifo_depth    = 2 ** DEF_FIFO_ADDR_W;

	// Samples to write, words to read and host block size for each row
	int          row_samples   [num_rows] = '{13, 51, 300, 1, 33, 96};
	int          row_reads     [num_rows] = '{0, 10, 40, 200, 0, 20};
	logic [15:0] row_blocksize [num_rows] = '{16'd1, 16'd8, 16'd60, 16'd16, 16'd0, 16'd20};

	logic        ti_clk;
	logic        reset;
	logic        write_to;
	sample_t     data_in;
	logic        read_from;
	logic [15:0] usb_blocksize;
	word_t       data_out;
	logic        out_rdy;
	count_t      num_words_in_fifo;
	count_t      in_fifo_numwords;
	count_t      out_fifo_numwords;
	count_t      ddr_numwords;

	// Reference model of the words held in write order across all stages
	word_t   stored_q [$];
	sample_t half_sample;
	bit      have_half;
	int      in_words;
	int      ram_words;
	int      out_words;
	int      samples_written;
	int      words_removed;
	word_t   last_word;
	integer  seed;
	int      cycle_count;
	int      timeout_limit;

	stream_buffer_top stream_buffer_top_inst (
		.ti_clk            (ti_clk),
		.reset             (reset),
		.write_to          (write_to),
		.data_in           (data_in),
		.read_from         (read_from),
		.usb_blocksize     (usb_blocksize),
		.data_out          (data_out),
		.out_rdy           (out_rdy),
		.num_words_in_fifo (num_words_in_fifo),
		.in_fifo_numwords  (in_fifo_numwords),
		.out_fifo_numwords (out_fifo_numwords),
		.ddr_numwords      (ddr_numwords)
	);

	always #50 ti_clk = ~ti_clk;

	always @(posedge ti_clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			fail_run($sformatf("Timeout: test still running after %0d cycles", timeout_limit));
		end
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopping at first error");
	endtask

	`include "stream_buffer_checks.svh"

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Apply every burst the engine may still start; fill bursts first
	task automatic settle_model();
		forever begin
			if (in_words >= DEF_BURST_LEN) begin
				in_words  -= DEF_BURST_LEN;
				ram_words += DEF_BURST_LEN;
			end else if (ram_words >= DEF_BURST_LEN
					&& out_words + DEF_BURST_LEN <= fifo_depth) begin
				ram_words -= DEF_BURST_LEN;
				out_words += DEF_BURST_LEN;
			end else begin
				break;
			end
		end
	endtask

	// One sample per cycle with the low sample of each pair first
	task automatic write_samples(input int n);
		sample_t s;
		for (int i = 0; i < n; i++) begin
			s = sample_t'($random(seed));
			write_to = 1'b1;
			data_in  = s;
			samples_written++;
			if (have_half) begin
				stored_q.push_back({s, half_sample});
				in_words++;
				have_half = 1'b0;
			end else begin
				half_sample = s;
				have_half   = 1'b1;
			end
			@(negedge ti_clk);
		end
		write_to = 1'b0;
	endtask

	// Reads are spaced so that drain bursts keep ahead of the host
	task automatic read_word();
		word_t expected;
		settle_model();
		if (out_words > 0) begin
			expected  = stored_q.pop_front();
			last_word = expected;
			out_words--;
			words_removed++;
		end else begin
			expected = last_word;
		end
		read_from = 1'b1;
		@(negedge ti_clk);
		read_from = 1'b0;
		check_word("data_out", data_out, expected);
		repeat (2) @(negedge ti_clk);
	endtask

	task automatic check_levels(input logic [15:0] blocksize);
		settle_model();
		check_count("in_fifo_numwords", in_fifo_numwords,
			count_t'(2 * in_words + int'(have_half)));
		check_count("ddr_numwords", ddr_numwords, count_t'(2 * ram_words));
		check_count("out_fifo_numwords", out_fifo_numwords, count_t'(2 * out_words));
		check_count("num_words_in_fifo", num_words_in_fifo,
			count_t'(samples_written - 2 * words_removed));
		check_count("num_words_in_fifo", num_words_in_fifo,
			count_t'(2 * (in_words + ram_words + out_words) + int'(have_half)));
		check_flag("out_rdy", out_rdy, out_words >= int'(blocksize));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		ti_clk          = 1'b0;
		reset           = 1'b1;
		write_to        = 1'b0;
		data_in         = '0;
		read_from       = 1'b0;
		usb_blocksize   = '0;
		seed            = 32'h395b_b0bf;
		have_half       = 1'b0;
		half_sample     = '0;
		in_words        = 0;
		ram_words       = 0;
		out_words       = 0;
		samples_written = 0;
		words_removed   = 0;
		last_word       = '0;
		cycle_count     = 0;
		timeout_limit   = 1000;
		for (int r = 0; r < num_rows; r++) begin
			timeout_limit += 4 * (row_samples[r] + row_reads[r]) + 2 * settle_cycles;
		end

		repeat (10) @(negedge ti_clk);
		reset = 1'b0;

		// Everything is cleared by reset
		check_flag("out_rdy", out_rdy, 1'b0);
		check_count("in_fifo_numwords", in_fifo_numwords, '0);
		check_count("ddr_numwords", ddr_numwords, '0);
		check_count("out_fifo_numwords", out_fifo_numwords, '0);
		check_count("num_words_in_fifo", num_words_in_fifo, '0);
		check_word("data_out", data_out, '0);

		for (int r = 0; r < num_rows; r++) begin
			usb_blocksize = row_blocksize[r];
			write_samples(row_samples[r]);
			repeat (settle_cycles) @(negedge ti_clk);
			check_levels(row_blocksize[r]);
			if (row_reads[r] > 0) begin
				for (int i = 0; i < row_reads[r]; i++) begin
					read_word();
				end
				repeat (settle_cycles) @(negedge ti_clk);
				check_levels(row_blocksize[r]);
			end
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+test
rtl/stream_buffer_pkg.sv
rtl/sample_packer.sv
rtl/stage_fifo.sv
rtl/bulk_ram.sv
rtl/burst_engine.sv
rtl/fill_monitor.sv
rtl/stream_buffer_top.sv
test/stream_buffer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the stream buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f src.f \
	--top-module stream_buffer_tb -o sim_stream_buffer; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_stream_buffer 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Result: PASSED" <<< "$sim_output"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
